// ==== hw/i3c_target_consts.svh ====
// I3C standby target constants for queue words and input synchronizers
`ifndef I3C_TARGET_CONSTS_SVH
`define I3C_TARGET_CONSTS_SVH

// Width of one TTI queue word
`define TTI_DATA_WIDTH 32

// Bus bytes packed into one queue word
`define TTI_BYTES_PER_WORD 4

// Flops on the sampled SCL/SDA lines
`define SYNC_STAGES 2

`endif

// ==== hw/i3c_target_pkg.sv ====
// I3C standby target types for bytes moved between the bus FSM and the data flow
`default_nettype none
`include "i3c_target_consts.svh"

package i3c_target_pkg;

  localparam int unsigned bus_byte_w = `TTI_DATA_WIDTH / `TTI_BYTES_PER_WORD;

  // Address header, first byte after a START
  typedef struct packed {
    logic [6:0] addr;
    logic       rnw;
  } bus_hdr_t;

  // Same bus byte seen as header or as plain data
  typedef union packed {
    bus_hdr_t              hdr;
    logic [bus_byte_w-1:0] raw;
  } bus_byte_u;

endpackage

`default_nettype wire

// ==== hw/bus_monitor.sv ====
// Bus monitor that synchronizes SCL/SDA and flags START, STOP and SCL edges
`timescale 1ns/1ps
`default_nettype none
`include "i3c_target_consts.svh"

module bus_monitor (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic enable_i,
  input  logic scl_i,
  input  logic sda_i,
  output logic start_det_o,
  output logic stop_det_o,
  output logic scl_rise_o,
  output logic scl_fall_o,
  output logic sda_sync_o
);

  logic [`SYNC_STAGES-1:0] scl_sync_q;
  logic [`SYNC_STAGES-1:0] sda_sync_q;
  logic                    scl_q;
  logic                    sda_q;
  logic                    scl_s;
  logic                    sda_s;

  assign scl_s = scl_sync_q[`SYNC_STAGES-1];
  assign sda_s = sda_sync_q[`SYNC_STAGES-1];

  // Level that matches the edge pulses below
  assign sda_sync_o = sda_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      // Idle bus has both lines high
      scl_sync_q  <= '1;
      sda_sync_q  <= '1;
      scl_q       <= 1'b1;
      sda_q       <= 1'b1;
      start_det_o <= 1'b0;
      stop_det_o  <= 1'b0;
      scl_rise_o  <= 1'b0;
      scl_fall_o  <= 1'b0;
    end else begin
      scl_sync_q  <= {scl_sync_q[`SYNC_STAGES-2:0], scl_i};
      sda_sync_q  <= {sda_sync_q[`SYNC_STAGES-2:0], sda_i};
      scl_q       <= scl_s;
      sda_q       <= sda_s;
      // SDA may only move with SCL high for START/STOP
      start_det_o <= enable_i & scl_s & scl_q & sda_q & ~sda_s;
      stop_det_o  <= enable_i & scl_s & scl_q & ~sda_q & sda_s;
      scl_rise_o  <= enable_i & scl_s & ~scl_q;
      scl_fall_o  <= enable_i & ~scl_s & scl_q;
    end
  end

endmodule

`default_nettype wire

// ==== hw/i3c_target_fsm.sv ====
// I3C target bit engine for header match, write/read bytes and the ninth bit
`timescale 1ns/1ps
`default_nettype none
`include "i3c_target_consts.svh"

module i3c_target_fsm
  import i3c_target_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       enable_i,
  input  logic       start_det_i,
  input  logic       stop_det_i,
  input  logic       scl_rise_i,
  input  logic       scl_fall_i,
  input  logic       sda_i,
  input  logic [6:0] static_addr_i,
  input  logic [6:0] dyn_addr_i,
  input  logic       dyn_addr_valid_i,
  input  logic       rx_byte_ready_i,
  input  logic       tx_byte_valid_i,
  input  bus_byte_u  tx_byte_i,
  output logic       sda_o,
  output logic       rx_byte_valid_o,
  output bus_byte_u  rx_byte_o,
  output logic       tx_byte_ready_o
);

  localparam logic [2:0] st_idle       = 3'd0;
  localparam logic [2:0] st_header     = 3'd1;
  localparam logic [2:0] st_header_ack = 3'd2;
  localparam logic [2:0] st_wr_byte    = 3'd3;
  localparam logic [2:0] st_wr_ack     = 3'd4;
  localparam logic [2:0] st_rd_byte    = 3'd5;
  localparam logic [2:0] st_rd_ack     = 3'd6;
  localparam logic [2:0] st_ignore     = 3'd7;

  localparam logic [3:0] last_bit = 4'(bus_byte_w);

  logic [2:0]            state_q;
  logic [3:0]            bit_cnt_q;
  bus_byte_u             shift_q;
  logic                  rnw_q;
  logic                  mack_q;
  logic                  byte_done;
  logic                  addr_match;
  logic                  shift_in;
  logic [bus_byte_w-1:0] tx_data;

  // Falling SCL that closes the eighth bit
  assign byte_done = scl_fall_i && (bit_cnt_q == last_bit);

  assign addr_match = (shift_q.hdr.addr == static_addr_i) ||
                      (dyn_addr_valid_i && (shift_q.hdr.addr == dyn_addr_i));

  assign shift_in = scl_rise_i && ((state_q == st_header) || (state_q == st_wr_byte));

  assign rx_byte_valid_o = (state_q == st_wr_byte) && byte_done;
  assign rx_byte_o       = shift_q;

  // Next byte is needed at the fall that ends an ACK phase
  assign tx_byte_ready_o = scl_fall_i &&
                           (((state_q == st_header_ack) && rnw_q) ||
                            ((state_q == st_rd_ack) && mack_q));

  // Released SDA when nothing to send
  assign tx_data = tx_byte_valid_i ? tx_byte_i.raw : '1;

  always_ff @(posedge clk_i) begin
    if (shift_in) begin
      shift_q.raw <= {shift_q.raw[bus_byte_w-2:0], sda_i};
    end else if (tx_byte_ready_o) begin
      shift_q.raw <= {tx_data[bus_byte_w-2:0], 1'b1};
    end else if (scl_fall_i && (state_q == st_rd_byte) && (bit_cnt_q != last_bit)) begin
      shift_q.raw <= {shift_q.raw[bus_byte_w-2:0], 1'b1};
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= st_idle;
      bit_cnt_q <= '0;
      rnw_q     <= 1'b0;
      mack_q    <= 1'b0;
      sda_o     <= 1'b1;
    end else if (!enable_i || stop_det_i) begin
      state_q <= st_idle;
      sda_o   <= 1'b1;
    end else if (start_det_i) begin
      // START and repeated START both restart the header
      state_q   <= st_header;
      bit_cnt_q <= '0;
      sda_o     <= 1'b1;
    end else begin
      case (state_q)
        st_header: begin
          if (scl_rise_i) begin
            bit_cnt_q <= bit_cnt_q + 4'd1;
          end else if (byte_done) begin
            rnw_q <= shift_q.hdr.rnw;
            if (addr_match) begin
              state_q <= st_header_ack;
              sda_o   <= 1'b0;
            end else begin
              state_q <= st_ignore;
            end
          end
        end
        st_header_ack: begin
          if (scl_fall_i) begin
            if (rnw_q) begin
              state_q   <= st_rd_byte;
              bit_cnt_q <= 4'd1;
              sda_o     <= tx_data[bus_byte_w-1];
            end else begin
              state_q   <= st_wr_byte;
              bit_cnt_q <= '0;
              sda_o     <= 1'b1;
            end
          end
        end
        st_wr_byte: begin
          if (scl_rise_i) begin
            bit_cnt_q <= bit_cnt_q + 4'd1;
          end else if (byte_done) begin
            // NACK when the flow cannot take the byte
            state_q <= st_wr_ack;
            sda_o   <= ~rx_byte_ready_i;
          end
        end
        st_wr_ack: begin
          if (scl_fall_i) begin
            state_q   <= st_wr_byte;
            bit_cnt_q <= '0;
            sda_o     <= 1'b1;
          end
        end
        st_rd_byte: begin
          if (byte_done) begin
            state_q <= st_rd_ack;
            sda_o   <= 1'b1;
          end else if (scl_fall_i) begin
            bit_cnt_q <= bit_cnt_q + 4'd1;
            sda_o     <= shift_q.raw[bus_byte_w-1];
          end
        end
        st_rd_ack: begin
          if (scl_rise_i) begin
            mack_q <= ~sda_i;
          end else if (scl_fall_i) begin
            if (mack_q) begin
              state_q   <= st_rd_byte;
              bit_cnt_q <= 4'd1;
              sda_o     <= tx_data[bus_byte_w-1];
            end else begin
              // Master NACK ends the read
              state_q <= st_ignore;
            end
          end
        end
        default: begin
          // Idle and ignore wait for the next START
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/flow_standby_i3c.sv ====
// Data flow that packs RX bytes into queue words and unpacks TX words into bytes
`timescale 1ns/1ps
`default_nettype none
`include "i3c_target_consts.svh"

module flow_standby_i3c
  import i3c_target_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       start_det_i,
  input  logic                       stop_det_i,
  input  logic                       rx_byte_valid_i,
  input  bus_byte_u                  rx_byte_i,
  input  logic                       tx_byte_ready_i,
  input  logic                       rx_queue_wready_i,
  input  logic                       tx_queue_rvalid_i,
  input  logic [`TTI_DATA_WIDTH-1:0] tx_queue_rdata_i,
  output logic                       rx_byte_ready_o,
  output logic                       tx_byte_valid_o,
  output bus_byte_u                  tx_byte_o,
  output logic                       rx_queue_wvalid_o,
  output logic [`TTI_DATA_WIDTH-1:0] rx_queue_wdata_o,
  output logic                       tx_queue_rready_o
);

  localparam int unsigned idx_w = $clog2(`TTI_BYTES_PER_WORD);
  localparam logic [idx_w-1:0] last_idx = idx_w'(`TTI_BYTES_PER_WORD - 1);

  logic [`TTI_DATA_WIDTH-1:0] rx_word_q;
  logic [idx_w-1:0]           rx_idx_q;
  logic                       rx_wvalid_q;

  logic [`TTI_DATA_WIDTH-1:0] tx_word_q;
  logic [idx_w-1:0]           tx_idx_q;
  logic                       tx_word_valid_q;
  logic                       tx_req_q;
  logic                       tx_load;

  // No new bytes while a packed word waits
  assign rx_byte_ready_o   = ~rx_wvalid_q;
  assign rx_queue_wvalid_o = rx_wvalid_q;
  assign rx_queue_wdata_o  = rx_word_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rx_word_q   <= '0;
      rx_idx_q    <= '0;
      rx_wvalid_q <= 1'b0;
    end else if (rx_wvalid_q) begin
      if (rx_queue_wready_i) begin
        // Cleared so a later partial word is zero padded
        rx_word_q   <= '0;
        rx_wvalid_q <= 1'b0;
      end
    end else if (rx_byte_valid_i) begin
      rx_word_q[rx_idx_q*bus_byte_w +: bus_byte_w] <= rx_byte_i.raw;
      rx_idx_q    <= rx_idx_q + 1'b1;
      rx_wvalid_q <= (rx_idx_q == last_idx);
    end else if ((start_det_i || stop_det_i) && (rx_idx_q != '0)) begin
      // Transfer ended mid word
      rx_idx_q    <= '0;
      rx_wvalid_q <= 1'b1;
    end
  end

  assign tx_queue_rready_o = tx_req_q;
  assign tx_load           = tx_req_q && tx_queue_rvalid_i;
  assign tx_byte_valid_o   = tx_word_valid_q;
  assign tx_byte_o         = bus_byte_u'(tx_word_q[tx_idx_q*bus_byte_w +: bus_byte_w]);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_word_valid_q <= 1'b0;
      tx_idx_q        <= '0;
      tx_req_q        <= 1'b0;
    end else if (tx_load) begin
      tx_word_valid_q <= 1'b1;
      tx_idx_q        <= '0;
      tx_req_q        <= 1'b0;
    end else if (tx_word_valid_q) begin
      if (stop_det_i && (tx_idx_q != '0)) begin
        // Drop what is left of a word already started
        tx_word_valid_q <= 1'b0;
        tx_idx_q        <= '0;
      end else if (tx_byte_ready_i) begin
        tx_idx_q <= tx_idx_q + 1'b1;
        if (tx_idx_q == last_idx) begin
          tx_word_valid_q <= 1'b0;
          tx_req_q        <= 1'b1;
        end
      end
    end else if (start_det_i) begin
      // Empty at START, fetch ahead of a possible read
      tx_req_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tx_load) begin
      tx_word_q <= tx_queue_rdata_i;
    end
  end

endmodule

`default_nettype wire

// ==== hw/controller_standby_i3c.sv ====
// Standby I3C controller top that answers as a target while another controller drives
`timescale 1ns/1ps
`default_nettype none
`include "i3c_target_consts.svh"

module controller_standby_i3c
  import i3c_target_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       i3c_standby_en_i,
  input  logic                       ctrl_scl_i,
  input  logic                       ctrl_sda_i,
  input  logic [6:0]                 static_addr_i,
  input  logic [6:0]                 dyn_addr_i,
  input  logic                       dyn_addr_valid_i,
  input  logic                       rx_queue_wready_i,
  input  logic                       tx_queue_rvalid_i,
  input  logic [`TTI_DATA_WIDTH-1:0] tx_queue_rdata_i,
  output logic                       ctrl_sda_o,
  output logic                       rx_queue_wvalid_o,
  output logic [`TTI_DATA_WIDTH-1:0] rx_queue_wdata_o,
  output logic                       tx_queue_rready_o
);

  logic      start_det;
  logic      stop_det;
  logic      scl_rise;
  logic      scl_fall;
  logic      sda_sync;

  logic      rx_byte_valid;
  bus_byte_u rx_byte;
  logic      rx_byte_ready;
  logic      tx_byte_valid;
  bus_byte_u tx_byte;
  logic      tx_byte_ready;

  bus_monitor xbus_monitor (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .enable_i    (i3c_standby_en_i),
    .scl_i       (ctrl_scl_i),
    .sda_i       (ctrl_sda_i),
    .start_det_o (start_det),
    .stop_det_o  (stop_det),
    .scl_rise_o  (scl_rise),
    .scl_fall_o  (scl_fall),
    .sda_sync_o  (sda_sync)
  );

  i3c_target_fsm xi3c_target_fsm (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .enable_i         (i3c_standby_en_i),
    .start_det_i      (start_det),
    .stop_det_i       (stop_det),
    .scl_rise_i       (scl_rise),
    .scl_fall_i       (scl_fall),
    .sda_i            (sda_sync),
    .static_addr_i    (static_addr_i),
    .dyn_addr_i       (dyn_addr_i),
    .dyn_addr_valid_i (dyn_addr_valid_i),
    .rx_byte_ready_i  (rx_byte_ready),
    .tx_byte_valid_i  (tx_byte_valid),
    .tx_byte_i        (tx_byte),
    .sda_o            (ctrl_sda_o),
    .rx_byte_valid_o  (rx_byte_valid),
    .rx_byte_o        (rx_byte),
    .tx_byte_ready_o  (tx_byte_ready)
  );

  // Repeated START also closes a partial RX word
  flow_standby_i3c xflow_standby_i3c (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .start_det_i       (start_det),
    .stop_det_i        (stop_det),
    .rx_byte_valid_i   (rx_byte_valid),
    .rx_byte_i         (rx_byte),
    .tx_byte_ready_i   (tx_byte_ready),
    .rx_queue_wready_i (rx_queue_wready_i),
    .tx_queue_rvalid_i (tx_queue_rvalid_i),
    .tx_queue_rdata_i  (tx_queue_rdata_i),
    .rx_byte_ready_o   (rx_byte_ready),
    .tx_byte_valid_o   (tx_byte_valid),
    .tx_byte_o         (tx_byte),
    .rx_queue_wvalid_o (rx_queue_wvalid_o),
    .rx_queue_wdata_o  (rx_queue_wdata_o),
    .tx_queue_rready_o (tx_queue_rready_o)
  );

endmodule

`default_nettype wire

// ==== test/tb_clk_gen.sv ====
// Testbench clock source with a 4 ns period
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always #2 clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== test/tb_controller_standby_i3c.sv ====
// Testbench for the standby I3C target with bus master tasks and queue models
`timescale 1ns/1ps
`default_nettype none
`include "i3c_target_consts.svh"

module tb_controller_standby_i3c
  import i3c_target_pkg::*;
;

  localparam int n_txn     = 48;
  localparam int max_bytes = 9;
  localparam int limit     = n_txn * max_bytes * 9 * 16 * 2;
  localparam logic [6:0] st_addr = 7'h2a;
  localparam logic [6:0] dy_addr = 7'h35;

  logic clk;
  logic rst_n, en, m_scl, m_sda, sda_bus, sda_o, dvalid;
  logic [6:0] static_addr, dyn_addr;
  logic wready, wvalid, rvalid, rready;
  logic [`TTI_DATA_WIDTH-1:0] wdata, rdata;
  logic rx_bp, tx_hold, tx_taken;
  int tx_gap, need_cnt, stop_cnt, cycles;
  logic [7:0] held_q[$];
  bus_byte_u exp_rd_q[$];
  logic [`TTI_DATA_WIDTH-1:0] got_q[$], exp_words[$], acc_word;
  int acc_cnt;

  // Open-drain bus, either side pulls low
  assign sda_bus = m_sda & sda_o;

  tb_clk_gen xtb_clk_gen (.clk_o(clk));

  controller_standby_i3c i_controller_standby_i3c (
    .clk_i(clk), .rst_n_i(rst_n), .i3c_standby_en_i(en),
    .ctrl_scl_i(m_scl), .ctrl_sda_i(sda_bus),
    .static_addr_i(static_addr), .dyn_addr_i(dyn_addr), .dyn_addr_valid_i(dvalid),
    .rx_queue_wready_i(wready), .tx_queue_rvalid_i(rvalid), .tx_queue_rdata_i(rdata),
    .ctrl_sda_o(sda_o), .rx_queue_wvalid_o(wvalid), .rx_queue_wdata_o(wdata),
    .tx_queue_rready_o(rready)
  );

  task automatic fail_run();
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [`TTI_DATA_WIDTH-1:0] exp_v,
                            input logic [`TTI_DATA_WIDTH-1:0] got_v);
    if (got_v !== exp_v) begin
      $display("FAIL %s expected %h got %h", name, exp_v, got_v);
      fail_run();
    end
  endtask

  task automatic check_byte(input string name, input bus_byte_u exp_v, input bus_byte_u got_v);
    if (got_v.raw !== exp_v.raw) begin
      $display("FAIL %s expected %h got %h", name, exp_v.raw, got_v.raw);
      fail_run();
    end
  endtask

  task automatic check_ack(input string name, input logic exp_v, input logic got_v);
    if (got_v !== exp_v) begin
      $display("FAIL %s expected %h got %h", name, exp_v, got_v);
      fail_run();
    end
  endtask

  task automatic hold(input int n);
    repeat (n) @(negedge clk);
  endtask

  // One SCL period, SDA set in the low phase and sampled mid high phase
  task automatic clock_bit(input logic b, output logic r);
    m_sda = b;
    hold(8);
    m_scl = 1'b1;
    hold(4);
    r = sda_bus;
    hold(4);
    m_scl = 1'b0;
  endtask

  task automatic bus_start();
    m_sda = 1'b1;
    hold(8);
    m_scl = 1'b1;
    hold(8);
    m_sda = 1'b0;
    hold(8);
    m_scl = 1'b0;
  endtask

  task automatic bus_stop();
    m_sda = 1'b0;
    hold(8);
    m_scl = 1'b1;
    hold(8);
    m_sda = 1'b1;
    stop_cnt = 4;
    hold(8);
  endtask

  task automatic write_byte(input logic [7:0] d, output logic ack);
    logic r;
    for (int i = 7; i >= 0; i--) begin
      clock_bit(d[i], r);
    end
    clock_bit(1'b1, ack);
  endtask

  task automatic read_byte(input logic mack, output bus_byte_u d);
    logic r;
    for (int i = 0; i < 8; i++) begin
      clock_bit(1'b1, r);
      d.raw = {d.raw[6:0], r};
    end
    clock_bit(~mack, r);
    // Target fetches the next byte at this SCL fall
    if (mack) begin
      need_cnt = 4;
    end
  endtask

  function automatic logic addr_acked(input logic [6:0] a);
    return en && ((a == static_addr) || (dvalid && (a == dyn_addr)));
  endfunction

  function automatic void add_rx_byte(input logic [7:0] b);
    acc_word[acc_cnt*8 +: 8] = b;
    acc_cnt++;
    if (acc_cnt == `TTI_BYTES_PER_WORD) begin
      exp_words.push_back(acc_word);
      acc_word = '0;
      acc_cnt = 0;
    end
  endfunction

  function automatic void flush_rx();
    if (acc_cnt != 0) begin
      exp_words.push_back(acc_word);
    end
    acc_word = '0;
    acc_cnt = 0;
  endfunction

  task automatic do_write(input logic [6:0] a, input int n, input logic end_stop);
    logic ack, hit;
    logic [7:0] d;
    hit = addr_acked(a);
    bus_start();
    write_byte({a, 1'b0}, ack);
    check_ack("header ack", ~hit, ack);
    for (int i = 0; i < n; i++) begin
      d = 8'($urandom);
      write_byte(d, ack);
      if (!hit) begin
        check_ack("data ack", 1'b1, ack);
      end else if (!rx_bp) begin
        check_ack("data ack", 1'b0, ack);
      end
      if (hit && !ack) begin
        add_rx_byte(d);
      end
    end
    if (end_stop) begin
      bus_stop();
    end
    flush_rx();
  endtask

  task automatic do_read(input logic [6:0] a, input int n);
    logic ack, hit;
    bus_byte_u d;
    hit = addr_acked(a);
    bus_start();
    write_byte({a, 1'b1}, ack);
    check_ack("header ack", ~hit, ack);
    if (hit) begin
      need_cnt = 4;
      for (int i = 0; i < n; i++) begin
        read_byte(i < n - 1, d);
        if (exp_rd_q.size() == 0) begin
          $display("Read byte arrived with no expected value");
          fail_run();
        end
        check_byte("read byte", exp_rd_q.pop_front(), d);
      end
    end
    bus_stop();
  endtask

  task automatic drain_check();
    hold(8);
    while (wvalid) begin
      hold(1);
    end
    while (exp_words.size() > 0) begin
      if (got_q.size() == 0) begin
        $display("RX queue is missing an expected word");
        fail_run();
      end
      check_word("rx_queue_wdata_o", exp_words.pop_front(), got_q.pop_front());
    end
    if (got_q.size() > 0) begin
      $display("RX queue received a word that was not expected");
      fail_run();
    end
  endtask

  // Queue models and TX byte prediction, all sampled at the rising edge
  always @(posedge clk) begin
    if (need_cnt == 1) begin
      if (held_q.size() > 0) begin
        exp_rd_q.push_back(bus_byte_u'(held_q.pop_front()));
      end else begin
        exp_rd_q.push_back(bus_byte_u'(8'hff));
      end
    end
    if (need_cnt > 0) need_cnt--;
    // Started word is dropped at STOP, untouched word is kept
    if ((stop_cnt == 1) && (held_q.size() inside {[1:3]})) held_q.delete();
    if (stop_cnt > 0) stop_cnt--;
    if (rready && rvalid) begin
      held_q.delete();
      for (int k = 0; k < `TTI_BYTES_PER_WORD; k++) held_q.push_back(rdata[k*8 +: 8]);
      tx_taken = 1'b1;
    end
    if (wvalid && wready) got_q.push_back(wdata);
    cycles++;
    if (cycles >= limit) begin
      $display("Timeout: the run went past %0d cycles", limit);
      fail_run();
    end
  end

  always @(negedge clk) begin
    // Long stalls so that a waiting word spans whole bus bytes
    wready = rx_bp ? ($urandom % 512 == 0) : 1'b1;
    if (tx_taken) begin
      tx_taken = 1'b0;
      rdata = $urandom;
      tx_gap = $urandom % 12;
    end
    if (tx_gap > 0 || tx_hold) begin
      rvalid = 1'b0;
      if (tx_gap > 0) tx_gap--;
    end else begin
      rvalid = 1'b1;
    end
  end

  initial begin
    logic [6:0] a;
    void'($urandom(32'hfdaf));
    rst_n = 1'b0;
    en = 1'b0;
    m_scl = 1'b1;
    m_sda = 1'b1;
    static_addr = st_addr;
    dyn_addr = dy_addr;
    dvalid = 1'b0;
    wready = 1'b1;
    rvalid = 1'b0;
    rdata = $urandom;
    rx_bp = 1'b0;
    tx_hold = 1'b0;
    tx_taken = 1'b0;
    tx_gap = 0;
    need_cnt = 0;
    stop_cnt = 0;
    cycles = 0;
    acc_word = '0;
    acc_cnt = 0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    hold(4);
    check_ack("ctrl_sda_o", 1'b1, sda_o);
    check_ack("rx_queue_wvalid_o", 1'b0, wvalid);
    check_ack("tx_queue_rready_o", 1'b0, rready);
    // Disabled target stays silent
    do_write(st_addr, 4, 1'b1);
    drain_check();
    en = 1'b1;
    repeat (10) begin
      do_write(st_addr, 1 + $urandom % 8, 1'b1);
      drain_check();
    end
    // Repeated START between two writes
    repeat (2) begin
      do_write(st_addr, 1 + $urandom % 8, 1'b0);
      do_write(st_addr, 1 + $urandom % 8, 1'b1);
      drain_check();
    end
    repeat (10) begin
      dvalid = 1'($urandom % 2);
      case ($urandom % 3)
        0: a = st_addr;
        1: a = dy_addr;
        default: a = 7'($urandom);
      endcase
      do_write(a, 1 + $urandom % 8, 1'b1);
      drain_check();
    end
    repeat (8) begin
      tx_hold = 1'($urandom % 2);
      do_read(st_addr, 1 + $urandom % 8);
    end
    tx_hold = 1'b0;
    rx_bp = 1'b1;
    repeat (10) begin
      do_write(st_addr, 1 + $urandom % 8, 1'b1);
      drain_check();
    end
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+hw
hw/i3c_target_pkg.sv
hw/bus_monitor.sv
hw/i3c_target_fsm.sv
hw/flow_standby_i3c.sv
hw/controller_standby_i3c.sv
test/tb_clk_gen.sv
test/tb_controller_standby_i3c.sv

// ==== Bender.yml ====
package:
  name: controller_standby_i3c

sources:
  - include_dirs:
      - hw
    files:
      - hw/i3c_target_pkg.sv
      - hw/bus_monitor.sv
      - hw/i3c_target_fsm.sv
      - hw/flow_standby_i3c.sv
      - hw/controller_standby_i3c.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/tb_clk_gen.sv
      - test/tb_controller_standby_i3c.sv
